// File: source/vt_pkg.sv
`default_nettype none

package vt_pkg;

   // Timestamp and timebase widths of one virtual time
   localparam int TS_WIDTH = 32;
   localparam int TB_WIDTH = 32;

   typedef logic [TS_WIDTH-1:0] ts_t;
   typedef logic [TB_WIDTH-1:0] tb_t;

   // Full virtual time, ordered by ts first, then tb
   // Compared as one unsigned number
   typedef struct packed {
      ts_t ts;
      tb_t tb;
   } vt_t;

   // Phase slots within one GVT period
   // Gaps between values leave the sources time to settle
   typedef enum logic [3:0] {
      PH_SRC_LATCH = 4'd0,
      PH_TQ_LATCH  = 4'd2,
      PH_PAIR_MIN  = 4'd8,
      PH_QUAD_MIN  = 4'd9,
      PH_PUBLISH   = 4'd10
   } gvt_phase_e;

endpackage

`default_nettype wire

// File: source/finish_pkg.sv
`default_nettype none

package finish_pkg;

   localparam int CQ_SLOT_WIDTH = 8;
   localparam int CHILD_ID_WIDTH = 4;
   localparam int REQ_IDX_WIDTH = 4;

   // Slot of a task in the commit queue
   typedef logic [CQ_SLOT_WIDTH-1:0] cq_slot_t;

   // Number of children a finishing task has enqueued
   typedef logic [CHILD_ID_WIDTH-1:0] child_id_t;

   // Index into the combined worker and restore requesters
   typedef logic [REQ_IDX_WIDTH-1:0] req_idx_t;

endpackage

`default_nettype wire

// File: source/tile_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module tile_ctrl
   import vt_pkg::*;
#(
   parameter int LOG_GVT_PERIOD = 4
) (
   input  wire logic clk_main_a0,
   input  wire logic rst_main_n_sync,

   input  wire logic tq_empty,
   input  wire logic tsb_empty,
   input  wire logic all_cores_idle,

   output logic      src_latch,
   output logic      tq_latch,
   output logic      pair_min,
   output logic      quad_min,
   output logic      publish,
   output tb_t       cur_tb,
   output logic      done
);

   logic [TB_WIDTH-1:0]                cycle_cnt;
   logic [LOG_GVT_PERIOD-1:0]          phase;
   logic [TB_WIDTH-LOG_GVT_PERIOD-1:0] prev_period;

   // Free-running cycle counter, zero in the first cycle out of reset
   always_ff @(posedge clk_main_a0) begin
      if (!rst_main_n_sync) begin
         cycle_cnt <= '0;
      end else begin
         cycle_cnt <= cycle_cnt + 1'b1;
      end
   end

   assign phase = cycle_cnt[LOG_GVT_PERIOD-1:0];

   // Schedule strobes for the LVT pipeline
   assign src_latch = (phase == LOG_GVT_PERIOD'(PH_SRC_LATCH));
   assign tq_latch  = (phase == LOG_GVT_PERIOD'(PH_TQ_LATCH));
   assign pair_min  = (phase == LOG_GVT_PERIOD'(PH_PAIR_MIN));
   assign quad_min  = (phase == LOG_GVT_PERIOD'(PH_QUAD_MIN));
   assign publish   = (phase == LOG_GVT_PERIOD'(PH_PUBLISH));

   // The published lvt belongs to the start of the previous period
   assign prev_period = cycle_cnt[TB_WIDTH-1:LOG_GVT_PERIOD] - 1'b1;
   assign cur_tb = {prev_period, {LOG_GVT_PERIOD{1'b0}}};

   // Tile is idle once the queues are drained and no core is busy
   always_ff @(posedge clk_main_a0) begin
      if (!rst_main_n_sync) begin
         done <= 1'b0;
      end else begin
         done <= tq_empty & tsb_empty & all_cores_idle;
      end
   end

   // Reduction stages never overlap within a period
   a_one_reduce_stage: assert property (
      @(posedge clk_main_a0) disable iff (!rst_main_n_sync)
      $onehot0({pair_min, quad_min, publish})
   );

endmodule

`default_nettype wire

// File: source/lvt_window_min.sv
`timescale 1ns/1ns
`default_nettype none

module lvt_window_min
   import vt_pkg::*;
(
   input  wire logic clk_main_a0,
   input  wire logic rst_main_n_sync,

   input  wire logic latch,
   input  wire ts_t  sample,

   output ts_t       fixed
);

   ts_t rolling;

   // Rolling minimum over the current window
   // At the latch the finished window moves into fixed
   always_ff @(posedge clk_main_a0) begin
      if (!rst_main_n_sync) begin
         rolling <= '0;
         fixed   <= '0;
      end else if (latch) begin
         fixed   <= rolling;
         rolling <= sample;
      end else if (sample < rolling) begin
         rolling <= sample;
      end
   end

   // Between latches the window only ever tightens
   a_rolling_no_rise: assert property (
      @(posedge clk_main_a0) disable iff (!rst_main_n_sync)
      !latch |=> (rolling <= $past(rolling))
   );

endmodule

`default_nettype wire

// File: source/lvt_reduce.sv
`timescale 1ns/1ns
`default_nettype none

module lvt_reduce
   import vt_pkg::*;
(
   input  wire logic clk_main_a0,
   input  wire logic rst_main_n_sync,

   input  wire logic pair_min,
   input  wire logic quad_min,
   input  wire logic publish,
   input  wire tb_t  cur_tb,

   input  wire ts_t  tq_fixed,
   input  wire ts_t  cm_fixed,
   input  wire ts_t  splitter_fixed,
   input  wire ts_t  tsb_ts,
   input  wire vt_t  lvt_cq,

   output vt_t       lvt
);

   vt_t tq_vt;
   vt_t cm_vt;
   vt_t splitter_vt;
   vt_t tsb_vt;

   vt_t tq_cq_min;
   vt_t cm_tsb_min;
   vt_t quad_min_vt;

   function automatic vt_t vt_min(input vt_t a, input vt_t b);
      return (a < b) ? a : b;
   endfunction

   // Sources only report ts, they share the period timebase
   assign tq_vt       = '{ts: tq_fixed,       tb: cur_tb};
   assign cm_vt       = '{ts: cm_fixed,       tb: cur_tb};
   assign splitter_vt = '{ts: splitter_fixed, tb: cur_tb};
   assign tsb_vt      = '{ts: tsb_ts,         tb: cur_tb};

   // Three stages, one per strobe
   always_ff @(posedge clk_main_a0) begin
      if (!rst_main_n_sync) begin
         tq_cq_min   <= '0;
         cm_tsb_min  <= '0;
         quad_min_vt <= '0;
         lvt         <= '0;
      end else begin
         if (pair_min) begin
            tq_cq_min  <= vt_min(tq_vt, lvt_cq);
            cm_tsb_min <= vt_min(cm_vt, tsb_vt);
         end
         if (quad_min) begin
            quad_min_vt <= vt_min(tq_cq_min, cm_tsb_min);
         end
         if (publish) begin
            lvt <= vt_min(quad_min_vt, splitter_vt);
         end
      end
   end

endmodule

`default_nettype wire

// File: source/finish_select.sv
`timescale 1ns/1ns
`default_nettype none

module finish_select
   import finish_pkg::*;
#(
   parameter int N_THREADS        = 4,
   parameter int UNDO_LOG_THREADS = 2
) (
   input  wire logic clk_main_a0,
   input  wire logic rst_main_n_sync,

   input  wire logic      [N_THREADS+UNDO_LOG_THREADS-1:0] finish_valid,
   input  wire cq_slot_t  [N_THREADS+UNDO_LOG_THREADS-1:0] finish_slot,
   input  wire child_id_t [N_THREADS-1:0]                  finish_num_children,
   input  wire logic      [N_THREADS-1:0]                  finish_undo_log_write,
   output logic           [N_THREADS+UNDO_LOG_THREADS-1:0] finish_ready,

   output logic           sel_valid,
   input  wire logic      sel_ready,
   output logic           sel_is_restore,
   output req_idx_t       sel_idx,
   output cq_slot_t       sel_slot,
   output child_id_t      sel_num_children,
   output logic           sel_undo_log_write
);

   localparam int N_REQ = N_THREADS + UNDO_LOG_THREADS;

   child_id_t [N_REQ-1:0] all_children;
   logic      [N_REQ-1:0] all_undo_write;

   // Restore threads never have children or undo-log writes
   always_comb begin
      all_children = '0;
      all_undo_write = '0;
      all_children[N_THREADS-1:0] = finish_num_children;
      all_undo_write[N_THREADS-1:0] = finish_undo_log_write;
   end

   // Walk down so the lowest valid index wins
   always_comb begin
      sel_idx = '0;
      sel_slot = '0;
      sel_num_children = '0;
      sel_undo_log_write = 1'b0;
      for (int i = N_REQ - 1; i >= 0; i--) begin
         if (finish_valid[i]) begin
            sel_idx = req_idx_t'(i);
            sel_slot = finish_slot[i];
            sel_num_children = all_children[i];
            sel_undo_log_write = all_undo_write[i];
         end
      end
   end

   assign sel_valid = |finish_valid;
   assign sel_is_restore = sel_valid && (sel_idx >= N_THREADS);

   always_comb begin
      for (int i = 0; i < N_REQ; i++) begin
         finish_ready[i] = sel_valid && sel_ready && (sel_idx == req_idx_t'(i));
      end
   end

   // At most one requester is acknowledged, and only a valid one
   a_ready_onehot: assert property (
      @(posedge clk_main_a0) disable iff (!rst_main_n_sync)
      $onehot0(finish_ready) && ((finish_ready & ~finish_valid) == '0)
   );

endmodule

`default_nettype wire

// File: source/tile_lvt_top.sv
`timescale 1ns/1ns
`default_nettype none

module tile_lvt_top
   import vt_pkg::*;
   import finish_pkg::*;
#(
   parameter int LOG_GVT_PERIOD   = 4,
   parameter int N_THREADS        = 4,
   parameter int UNDO_LOG_THREADS = 2
) (
   input  wire logic clk_main_a0,
   input  wire logic rst_main_n_sync,

   input  wire ts_t  lvt_tq_ts,
   input  wire ts_t  lvt_cm_ts,
   input  wire ts_t  lvt_splitter_ts,
   input  wire ts_t  lvt_tsb_ts,
   input  wire vt_t  lvt_cq,
   output vt_t       lvt,

   input  wire logic tq_empty,
   input  wire logic tsb_empty,
   input  wire logic all_cores_idle,
   output logic      done,

   input  wire logic      [N_THREADS+UNDO_LOG_THREADS-1:0] finish_valid,
   input  wire cq_slot_t  [N_THREADS+UNDO_LOG_THREADS-1:0] finish_slot,
   input  wire child_id_t [N_THREADS-1:0]                  finish_num_children,
   input  wire logic      [N_THREADS-1:0]                  finish_undo_log_write,
   output logic           [N_THREADS+UNDO_LOG_THREADS-1:0] finish_ready,

   output logic      sel_valid,
   input  wire logic sel_ready,
   output logic      sel_is_restore,
   output req_idx_t  sel_idx,
   output cq_slot_t  sel_slot,
   output child_id_t sel_num_children,
   output logic      sel_undo_log_write
);

   logic src_latch;
   logic tq_latch;
   logic pair_min;
   logic quad_min;
   logic publish;
   tb_t  cur_tb;

   ts_t  tq_fixed;
   ts_t  cm_fixed;
   ts_t  splitter_fixed;

   tile_ctrl #(
      .LOG_GVT_PERIOD(LOG_GVT_PERIOD)
   ) tile_ctrl_inst (
      .clk_main_a0    (clk_main_a0),
      .rst_main_n_sync(rst_main_n_sync),
      .tq_empty       (tq_empty),
      .tsb_empty      (tsb_empty),
      .all_cores_idle (all_cores_idle),
      .src_latch      (src_latch),
      .tq_latch       (tq_latch),
      .pair_min       (pair_min),
      .quad_min       (quad_min),
      .publish        (publish),
      .cur_tb         (cur_tb),
      .done           (done)
   );

   // TQ timestamp arrives late, so its window closes two cycles later
   lvt_window_min tq_window (
      .clk_main_a0    (clk_main_a0),
      .rst_main_n_sync(rst_main_n_sync),
      .latch          (tq_latch),
      .sample         (lvt_tq_ts),
      .fixed          (tq_fixed)
   );

   lvt_window_min cm_window (
      .clk_main_a0    (clk_main_a0),
      .rst_main_n_sync(rst_main_n_sync),
      .latch          (src_latch),
      .sample         (lvt_cm_ts),
      .fixed          (cm_fixed)
   );

   lvt_window_min splitter_window (
      .clk_main_a0    (clk_main_a0),
      .rst_main_n_sync(rst_main_n_sync),
      .latch          (src_latch),
      .sample         (lvt_splitter_ts),
      .fixed          (splitter_fixed)
   );

   lvt_reduce lvt_reduce_inst (
      .clk_main_a0    (clk_main_a0),
      .rst_main_n_sync(rst_main_n_sync),
      .pair_min       (pair_min),
      .quad_min       (quad_min),
      .publish        (publish),
      .cur_tb         (cur_tb),
      .tq_fixed       (tq_fixed),
      .cm_fixed       (cm_fixed),
      .splitter_fixed (splitter_fixed),
      .tsb_ts         (lvt_tsb_ts),
      .lvt_cq         (lvt_cq),
      .lvt            (lvt)
   );

   finish_select #(
      .N_THREADS       (N_THREADS),
      .UNDO_LOG_THREADS(UNDO_LOG_THREADS)
   ) finish_select_inst (
      .clk_main_a0          (clk_main_a0),
      .rst_main_n_sync      (rst_main_n_sync),
      .finish_valid         (finish_valid),
      .finish_slot          (finish_slot),
      .finish_num_children  (finish_num_children),
      .finish_undo_log_write(finish_undo_log_write),
      .finish_ready         (finish_ready),
      .sel_valid            (sel_valid),
      .sel_ready            (sel_ready),
      .sel_is_restore       (sel_is_restore),
      .sel_idx              (sel_idx),
      .sel_slot             (sel_slot),
      .sel_num_children     (sel_num_children),
      .sel_undo_log_write   (sel_undo_log_write)
   );

endmodule

`default_nettype wire

// File: testbench/tb_tile_lvt.sv
`timescale 1ns/1ns
`default_nettype none

module tb_tile_lvt
   import vt_pkg::*;
   import finish_pkg::*;
();

   localparam int LOG_GVT_PERIOD   = 4;
   localparam int N_THREADS        = 4;
   localparam int UNDO_LOG_THREADS = 2;
   localparam int N_REQ            = N_THREADS + UNDO_LOG_THREADS;
   localparam int TARGET_PUBLISHES = 10;
   localparam int MAX_CYCLES       = 20 << LOG_GVT_PERIOD;

   logic clk_main_a0;
   logic rst_main_n_sync;

   ts_t  lvt_tq_ts;
   ts_t  lvt_cm_ts;
   ts_t  lvt_splitter_ts;
   ts_t  lvt_tsb_ts;
   vt_t  lvt_cq;
   vt_t  lvt;

   logic tq_empty;
   logic tsb_empty;
   logic all_cores_idle;
   logic done;

   logic      [N_REQ-1:0]     finish_valid;
   cq_slot_t  [N_REQ-1:0]     finish_slot;
   child_id_t [N_THREADS-1:0] finish_num_children;
   logic      [N_THREADS-1:0] finish_undo_log_write;
   logic      [N_REQ-1:0]     finish_ready;

   logic      sel_valid;
   logic      sel_ready;
   logic      sel_is_restore;
   req_idx_t  sel_idx;
   cq_slot_t  sel_slot;
   child_id_t sel_num_children;
   logic      sel_undo_log_write;

   // Reference model, values as they stand after the last rising edge
   logic [31:0] m_cnt;
   ts_t         m_tq_roll;
   ts_t         m_tq_fix;
   ts_t         m_cm_roll;
   ts_t         m_cm_fix;
   ts_t         m_sp_roll;
   ts_t         m_sp_fix;
   logic [63:0] m_pair_a;
   logic [63:0] m_pair_b;
   logic [63:0] m_quad;
   logic [63:0] m_lvt;
   logic        m_done;
   int          m_publishes;
   int          cycles;

   tile_lvt_top #(
      .LOG_GVT_PERIOD  (LOG_GVT_PERIOD),
      .N_THREADS       (N_THREADS),
      .UNDO_LOG_THREADS(UNDO_LOG_THREADS)
   ) tile_lvt_top_inst (
      .clk_main_a0          (clk_main_a0),
      .rst_main_n_sync      (rst_main_n_sync),
      .lvt_tq_ts            (lvt_tq_ts),
      .lvt_cm_ts            (lvt_cm_ts),
      .lvt_splitter_ts      (lvt_splitter_ts),
      .lvt_tsb_ts           (lvt_tsb_ts),
      .lvt_cq               (lvt_cq),
      .lvt                  (lvt),
      .tq_empty             (tq_empty),
      .tsb_empty            (tsb_empty),
      .all_cores_idle       (all_cores_idle),
      .done                 (done),
      .finish_valid         (finish_valid),
      .finish_slot          (finish_slot),
      .finish_num_children  (finish_num_children),
      .finish_undo_log_write(finish_undo_log_write),
      .finish_ready         (finish_ready),
      .sel_valid            (sel_valid),
      .sel_ready            (sel_ready),
      .sel_is_restore       (sel_is_restore),
      .sel_idx              (sel_idx),
      .sel_slot             (sel_slot),
      .sel_num_children     (sel_num_children),
      .sel_undo_log_write   (sel_undo_log_write)
   );

   initial begin
      clk_main_a0 = 1'b0;
      forever #4 clk_main_a0 = ~clk_main_a0;
   end

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      assert (actual === expected) else begin
         $display("Fail at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
         $display("Errors found");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   function automatic logic [63:0] smaller_vt(input logic [63:0] a, input logic [63:0] b);
      return (a < b) ? a : b;
   endfunction

   // Start of the period before the one the counter is in
   function automatic tb_t period_timebase(input logic [31:0] cnt);
      return ((cnt >> LOG_GVT_PERIOD) - 32'd1) << LOG_GVT_PERIOD;
   endfunction

   task automatic step_window(input logic latch, input ts_t sample,
                              inout ts_t rolling, inout ts_t fixed);
      if (latch) begin
         fixed = rolling;
         rolling = sample;
      end else if (sample < rolling) begin
         rolling = sample;
      end
   endtask

   // Model one rising edge with the inputs that were just driven
   task automatic advance_model();
      int          phase;
      tb_t         tb;
      logic [63:0] tq_vt;
      logic [63:0] cm_vt;
      logic [63:0] sp_vt;
      logic [63:0] tsb_vt;
      phase = int'(m_cnt[LOG_GVT_PERIOD-1:0]);
      tb = period_timebase(m_cnt);
      tq_vt = {m_tq_fix, tb};
      cm_vt = {m_cm_fix, tb};
      sp_vt = {m_sp_fix, tb};
      tsb_vt = {lvt_tsb_ts, tb};
      // Phases 8, 9 and 10 run the three reduction stages
      if (phase == 8) begin
         m_pair_a = smaller_vt(tq_vt, lvt_cq);
         m_pair_b = smaller_vt(cm_vt, tsb_vt);
      end
      if (phase == 9) begin
         m_quad = smaller_vt(m_pair_a, m_pair_b);
      end
      if (phase == 10) begin
         m_lvt = smaller_vt(m_quad, sp_vt);
         m_publishes++;
      end
      step_window(phase == 2, lvt_tq_ts, m_tq_roll, m_tq_fix);
      step_window(phase == 0, lvt_cm_ts, m_cm_roll, m_cm_fix);
      step_window(phase == 0, lvt_splitter_ts, m_sp_roll, m_sp_fix);
      m_done = tq_empty & tsb_empty & all_cores_idle;
      m_cnt = m_cnt + 32'd1;
   endtask

   task automatic check_finish();
      logic       found;
      int         idx;
      logic [N_REQ-1:0] exp_ready;
      child_id_t  exp_children;
      logic       exp_undo;
      found = 1'b0;
      idx = 0;
      for (int i = 0; i < N_REQ; i++) begin
         if (!found && finish_valid[i]) begin
            found = 1'b1;
            idx = i;
         end
      end
      exp_ready = (found && sel_ready) ? (N_REQ'(1) << idx) : '0;
      check_value("sel_valid", 64'(found), 64'(sel_valid));
      check_value("finish_ready", 64'(exp_ready), 64'(finish_ready));
      if (found) begin
         // Restore requesters carry no children and no undo-log write
         if (idx < N_THREADS) begin
            exp_children = finish_num_children[idx];
            exp_undo = finish_undo_log_write[idx];
         end else begin
            exp_children = '0;
            exp_undo = 1'b0;
         end
         check_value("sel_idx", 64'(idx), 64'(sel_idx));
         check_value("sel_slot", 64'(finish_slot[idx]), 64'(sel_slot));
         check_value("sel_is_restore", 64'(idx >= N_THREADS), 64'(sel_is_restore));
         check_value("sel_num_children", 64'(exp_children), 64'(sel_num_children));
         check_value("sel_undo_log_write", 64'(exp_undo), 64'(sel_undo_log_write));
      end
   endtask

   task automatic check_outputs();
      if (m_publishes == 0) begin
         check_value("lvt before first publish", 64'd0, 64'(lvt));
      end
      check_value("lvt.ts", 64'(m_lvt[63:32]), 64'(lvt.ts));
      check_value("lvt.tb", 64'(m_lvt[31:0]), 64'(lvt.tb));
      check_value("done", 64'(m_done), 64'(done));
      check_finish();
   endtask

   // Small timestamp ranges keep the minima moving
   task automatic drive_inputs();
      lvt_tq_ts = ts_t'($urandom_range(0, 63));
      lvt_cm_ts = ts_t'($urandom_range(0, 63));
      lvt_splitter_ts = ts_t'($urandom_range(0, 63));
      lvt_tsb_ts = ts_t'($urandom_range(0, 63));
      lvt_cq.ts = ts_t'($urandom_range(0, 80));
      lvt_cq.tb = tb_t'($urandom);
      tq_empty = ($urandom_range(0, 3) != 0);
      tsb_empty = ($urandom_range(0, 3) != 0);
      all_cores_idle = ($urandom_range(0, 3) != 0);
      finish_valid = N_REQ'($urandom);
      for (int i = 0; i < N_REQ; i++) begin
         finish_slot[i] = cq_slot_t'($urandom);
      end
      for (int i = 0; i < N_THREADS; i++) begin
         finish_num_children[i] = child_id_t'($urandom);
         finish_undo_log_write[i] = 1'($urandom);
      end
      sel_ready = 1'($urandom);
   endtask

   initial begin
      void'($urandom(32'h7538_5921));
      rst_main_n_sync = 1'b0;
      lvt_tq_ts = '0;
      lvt_cm_ts = '0;
      lvt_splitter_ts = '0;
      lvt_tsb_ts = '0;
      lvt_cq = '0;
      tq_empty = 1'b0;
      tsb_empty = 1'b0;
      all_cores_idle = 1'b0;
      finish_valid = '0;
      finish_slot = '0;
      finish_num_children = '0;
      finish_undo_log_write = '0;
      sel_ready = 1'b0;
      m_cnt = '0;
      m_tq_roll = '0;
      m_tq_fix = '0;
      m_cm_roll = '0;
      m_cm_fix = '0;
      m_sp_roll = '0;
      m_sp_fix = '0;
      m_pair_a = '0;
      m_pair_b = '0;
      m_quad = '0;
      m_lvt = '0;
      m_done = 1'b0;
      m_publishes = 0;
      cycles = 0;

      repeat (5) @(posedge clk_main_a0);
      @(negedge clk_main_a0);
      check_value("lvt in reset", 64'd0, 64'(lvt));
      check_value("done in reset", 64'd0, 64'(done));
      rst_main_n_sync = 1'b1;
      drive_inputs();
      advance_model();

      // Run until enough periods have published, bounded by a cycle limit
      while (m_publishes < TARGET_PUBLISHES) begin
         if (cycles >= MAX_CYCLES) begin
            $display("Timed out waiting for %0d lvt publishes", TARGET_PUBLISHES);
            $display("Errors found");
            $fatal(1, "Timeout");
         end else begin
            @(negedge clk_main_a0);
            check_outputs();
            drive_inputs();
            advance_model();
            cycles++;
         end
      end
      @(negedge clk_main_a0);
      check_outputs();

      $display("No errors");
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
source/vt_pkg.sv
source/finish_pkg.sv
source/tile_ctrl.sv
source/lvt_window_min.sv
source/lvt_reduce.sv
source/finish_select.sv
source/tile_lvt_top.sv
testbench/tb_tile_lvt.sv

// File: run_sim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_tile_lvt -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
   echo "Verilator build failed"
   exit "$status"
fi

./obj_dir/Vtb_tile_lvt
status=$?
if [ "$status" -ne 0 ]; then
   echo "Simulation failed"
   exit "$status"
fi

exit 0
